//--- dv/pad_turnaround_trace.txt
// tests: 0 reset, 1 write_launch, 2 turnaround, 3 read_capture, 4 independent_lanes
// test dly dq_tri dqs_tri wr_data wr_dm pad_dq_in  pad_dq_out pad_dm_out dq_oe dqs_oe rd_data rd_valid
0 0 3 3 0000 0 0000  0000 0 0 0 xxxx 0
0 0 3 3 0000 0 0000  0000 0 0 0 0000 3
1 0 0 0 a1b2 1 xxxx  0000 0 0 0 0000 3
1 0 0 0 c3d4 2 xxxx  0000 0 0 0 xxxx 3
1 0 0 0 e5f6 3 xxxx  c3d4 2 3 3 xxxx 3
1 0 3 3 0789 0 xxxx  e5f6 3 3 3 xxxx 0
1 0 3 3 0000 0 xxxx  0789 0 3 3 xxxx 0
2 0 3 3 0000 0 xxxx  0789 0 0 0 xxxx 0
2 0 3 3 0000 0 1111  0789 0 0 0 xxxx 0
2 0 3 3 0000 0 2222  0789 0 0 0 1111 3
3 0 3 3 0000 0 3c5a  0789 0 0 0 2222 3
3 0 3 3 0000 0 a5c3  0789 0 0 0 3c5a 3
3 0 3 3 0000 0 0ff0  0789 0 0 0 a5c3 3
3 0 3 3 0000 0 f00f  0789 0 0 0 0ff0 3
3 0 3 3 0000 0 1357  0789 0 0 0 f00f 3
3 0 3 3 0000 0 2468  0789 0 0 0 1357 3
3 0 3 3 0000 0 9bdf  0789 0 0 0 2468 3
3 0 3 3 0000 0 ace0  0789 0 0 0 9bdf 3
3 0 3 3 0000 0 5555  0789 0 0 0 ace0 3
3 0 3 3 0000 0 aaaa  0789 0 0 0 5555 3
3 0 3 3 0000 0 0001  0789 0 0 0 aaaa 3
3 0 3 3 0000 0 8000  0789 0 0 0 0001 3
1 5 3 3 0000 0 xxxx  0789 0 0 0 8000 3
1 5 0 0 0000 0 xxxx  0789 0 0 0 xxxx 3
1 5 0 0 0000 0 xxxx  0789 0 0 0 xxxx 3
1 5 3 3 0000 0 xxxx  0789 0 0 0 xxxx 3
1 5 3 3 0000 0 xxxx  0789 0 0 0 xxxx 3
1 5 3 3 0000 0 xxxx  0789 0 0 0 xxxx 3
1 5 3 3 0000 0 xxxx  0789 0 0 0 xxxx 3
1 5 3 3 1122 1 xxxx  0789 0 0 0 xxxx 3
1 5 3 3 3344 2 xxxx  1122 1 3 3 xxxx 3
1 5 3 3 0000 0 xxxx  3344 2 3 3 xxxx 0
2 5 3 3 0000 0 xxxx  3344 2 0 0 xxxx 0
2 5 3 3 0000 0 4242  3344 2 0 0 xxxx 0
2 5 3 3 0000 0 5151  3344 2 0 0 4242 3
3 5 3 3 0000 0 6262  3344 2 0 0 5151 3
3 5 3 3 0000 0 7373  3344 2 0 0 6262 3
3 5 3 3 0000 0 8484  3344 2 0 0 7373 3
3 5 3 3 0000 0 9595  3344 2 0 0 8484 3
3 5 3 3 0000 0 a6a6  3344 2 0 0 9595 3
3 5 3 3 0000 0 b7b7  3344 2 0 0 a6a6 3
3 5 3 3 0000 0 c8c8  3344 2 0 0 b7b7 3
1 f 3 3 0000 0 1e1e  3344 2 0 0 c8c8 3
1 f 2 1 0000 0 1e1e  3344 2 0 0 1e1e 3
1 f 2 1 0000 0 1e1e  3344 2 0 0 1e1e 3
1 f 3 3 0000 0 1e1e  3344 2 0 0 1e1e 3
1 f 3 3 0000 0 1e1e  3344 2 0 0 1e1e 3
1 f 3 3 0000 0 1e1e  3344 2 0 0 1e1e 3
1 f 3 3 0000 0 1e1e  3344 2 0 0 1e1e 3
1 f 3 3 0000 0 1e1e  3344 2 0 0 1e1e 3
1 f 3 3 0000 0 1e1e  3344 2 0 0 1e1e 3
1 f 3 3 0000 0 1e1e  3344 2 0 0 1e1e 3
1 f 3 3 0000 0 1e1e  3344 2 0 0 1e1e 3
1 f 3 3 0000 0 1e1e  3344 2 0 0 1e1e 3
1 f 3 3 0000 0 1e1e  3344 2 0 0 1e1e 3
1 f 3 3 0000 0 1e1e  3344 2 0 0 1e1e 3
1 f 3 3 0000 0 1e1e  3344 2 0 0 1e1e 3
1 f 3 3 0000 0 1e1e  3344 2 0 0 1e1e 3
1 f 3 3 0000 0 2d2d  3344 2 0 0 1e1e 3
1 f 3 3 abcd 3 3c3c  3344 2 0 0 2d2d 3
1 f 3 3 ef01 0 4b4b  33cd 3 1 2 3c3c 3
4 f 3 3 0000 0 5a5a  3301 2 1 2 4b3c 2
4 f 3 3 0000 0 6969  3301 2 0 0 5a3c 2
4 f 3 3 0000 0 7878  3301 2 0 0 693c 2
4 f 3 3 0000 0 8787  3301 2 0 0 7878 3

//--- dv/tb_pad_turnaround.sv
`timescale 1ns/1ns
`default_nettype none

module tb_pad_turnaround;

    localparam int NUM_LINES  = 65;
    localparam int NUM_FIELDS = 13;  // words per trace line
    localparam int NUM_TESTS  = 5;
    localparam int PERIOD     = 100;

    logic              mclk;
    logic              rst;
    ddr_pad_pkg::dly_t dly_cfg;
    logic [1:0]        dq_tri;
    logic [1:0]        dqs_tri;
    logic [15:0]       wr_data;
    logic [1:0]        wr_dm;
    logic [15:0]       pad_dq_in;
    logic [15:0]       pad_dq_out;
    logic [1:0]        pad_dm_out;
    logic [1:0]        pad_dq_oe;
    logic [1:0]        pad_dqs_oe;
    logic [15:0]       rd_data;
    logic [1:0]        rd_valid;

    logic [15:0] trace_mem [NUM_LINES*NUM_FIELDS];
    string       test_name [NUM_TESTS];
    int          last_line [NUM_TESTS];
    bit          test_failed [NUM_TESTS];
    int          seed;
    int          pass_count;
    int          fail_count;

    pad_turnaround_top u_pad_turnaround_top (
        .mclk       (mclk),
        .rst        (rst),
        .dly_cfg    (dly_cfg),
        .dq_tri     (dq_tri),
        .dqs_tri    (dqs_tri),
        .wr_data    (wr_data),
        .wr_dm      (wr_dm),
        .pad_dq_in  (pad_dq_in),
        .pad_dq_out (pad_dq_out),
        .pad_dm_out (pad_dm_out),
        .pad_dq_oe  (pad_dq_oe),
        .pad_dqs_oe (pad_dqs_oe),
        .rd_data    (rd_data),
        .rd_valid   (rd_valid)
    );

    always #(PERIOD/2) mclk = ~mclk;

    // x in an expected word means that field is not compared on this line
    task automatic compare_field(input int line, input string field,
                                 input logic [15:0] exp, input logic [15:0] act);
        int t;
        t = trace_mem[line*NUM_FIELDS];
        if (!$isunknown(exp)) begin
            assert (act === exp) else begin
                $display("mismatch test %s line %0d %s expected %h actual %h",
                         test_name[t], line, field, exp, act);
                test_failed[t] = 1'b1;
            end
        end
    endtask

    initial begin
        #((NUM_LINES + 10) * PERIOD);
        $display("run timed out before the trace was finished");
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin
        int b;
        int t;
        mclk      = 1'b0;
        rst       = 1'b1;
        dly_cfg   = '0;
        dq_tri    = 2'b11;  // all released
        dqs_tri   = 2'b11;
        wr_data   = '0;
        wr_dm     = '0;
        pad_dq_in = '0;
        seed      = 73;
        pass_count = 0;
        fail_count = 0;
        test_name[0] = "reset";
        test_name[1] = "write_launch";
        test_name[2] = "turnaround";
        test_name[3] = "read_capture";
        test_name[4] = "independent_lanes";
        for (int i = 0; i < NUM_TESTS; i++) begin
            last_line[i]   = -1;
            test_failed[i] = 1'b0;
        end

        $readmemh("dv/pad_turnaround_trace.txt", trace_mem);
        if ($isunknown(trace_mem[0])) begin
            $display("trace file could not be read");
            $display("SOME TESTS FAILED");
            $finish;
        end else begin
            for (int l = 0; l < NUM_LINES; l++) begin
                last_line[trace_mem[l*NUM_FIELDS]] = l;
            end

            @(posedge mclk);  // first reset edge
            for (int l = 0; l < NUM_LINES; l++) begin
                b = l * NUM_FIELDS;
                @(posedge mclk);
                rst     <= 1'b0;
                dly_cfg <= trace_mem[b+1][3:0];
                dq_tri  <= trace_mem[b+2][1:0];
                dqs_tri <= trace_mem[b+3][1:0];
                wr_data <= trace_mem[b+4];
                wr_dm   <= trace_mem[b+5][1:0];
                if ($isunknown(trace_mem[b+6])) begin
                    pad_dq_in <= $random(seed);  // pad value not checked later
                end else begin
                    pad_dq_in <= trace_mem[b+6];
                end

                @(negedge mclk);
                compare_field(l, "pad_dq_out", trace_mem[b+7], pad_dq_out);
                compare_field(l, "pad_dm_out", trace_mem[b+8], {14'd0, pad_dm_out});
                compare_field(l, "pad_dq_oe", trace_mem[b+9], {14'd0, pad_dq_oe});
                compare_field(l, "pad_dqs_oe", trace_mem[b+10], {14'd0, pad_dqs_oe});
                compare_field(l, "rd_data", trace_mem[b+11], rd_data);
                compare_field(l, "rd_valid", trace_mem[b+12], {14'd0, rd_valid});

                t = trace_mem[b];
                if (last_line[t] == l) begin
                    if (test_failed[t]) begin
                        $display("test %s failed", test_name[t]);
                        fail_count++;
                    end else begin
                        $display("test %s passed", test_name[t]);
                        pass_count++;
                    end
                end
            end

            $display("%0d tests passed, %0d tests failed", pass_count, fail_count);
            if (fail_count == 0) begin
                $display("ALL TESTS PASSED");
            end else begin
                $display("SOME TESTS FAILED");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- flist.f
source/ddr_pad_pkg.sv
source/pad_lane_if.sv
source/dly_16.sv
source/lane_dir_fsm.sv
source/byte_lane.sv
source/pad_turnaround_top.sv
dv/tb_pad_turnaround.sv

//--- source/byte_lane.sv
`timescale 1ns/1ns
`default_nettype none

module byte_lane (
    input  logic                    mclk,
    input  logic                    rst,
    pad_lane_if.lane                lane,
    input  ddr_pad_pkg::lane_data_t wr_byte,
    input  logic                    wr_mask,
    input  ddr_pad_pkg::lane_data_t pad_in,
    output ddr_pad_pkg::lane_data_t pad_out,
    output logic                    dm_out,
    output ddr_pad_pkg::lane_data_t rd_byte,
    output logic                    rd_valid
);

    // write side toward the pads
    always_ff @(posedge mclk) begin
        if (rst) begin
            pad_out <= '0;
            dm_out  <= 1'b0;
        end else if (lane.drive) begin
            pad_out <= wr_byte;
            dm_out  <= wr_mask;
        end
    end

    // read side, pad value sampled while released
    always_ff @(posedge mclk) begin
        if (lane.capture) begin
            rd_byte <= pad_in;
        end
    end

    always_ff @(posedge mclk) begin
        if (rst) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= lane.capture;  // one cycle after the sample edge
        end
    end

    // a cycle of driving is never reported as read data
    a_no_rd_after_drive : assert property (@(posedge mclk) disable iff (rst)
        lane.oe_dq |=> !rd_valid);

endmodule

`default_nettype wire

//--- source/ddr_pad_pkg.sv
`default_nettype none

package ddr_pad_pkg;

    localparam int LANE_W    = 8;   // bits per byte lane
    localparam int NUM_LANES = 2;   // lower and upper byte
    localparam int DLY_DEPTH = 16;  // delay line taps

    typedef logic [LANE_W-1:0] lane_data_t;

    // setting d selects tap d, i.e. d+1 cycles of delay
    typedef logic [$clog2(DLY_DEPTH)-1:0] dly_t;

    typedef enum logic [1:0] {
        RX    = 2'd0,  // pads released, read data captured
        DRIVE = 2'd1,  // write data on the pads
        GAP   = 2'd2   // one released cycle after a write burst
    } dir_state_t;

endpackage

`default_nettype wire

//--- source/dly_16.sv
`timescale 1ns/1ns
`default_nettype none

module dly_16 #(
    parameter int WIDTH = 4
) (
    input  logic                mclk,
    input  logic                rst,
    input  ddr_pad_pkg::dly_t   dly,
    input  logic [WIDTH-1:0]    din,
    output logic [WIDTH-1:0]    dout
);

    logic [WIDTH-1:0] taps [ddr_pad_pkg::DLY_DEPTH];

    logic [$clog2(ddr_pad_pkg::DLY_DEPTH+1)-1:0] settle_cnt;  // cycles since dly change
    ddr_pad_pkg::dly_t                           dly_q;

    always_ff @(posedge mclk) begin
        if (rst) begin
            for (int i = 0; i < ddr_pad_pkg::DLY_DEPTH; i++) begin
                taps[i] <= '1;  // released
            end
        end else begin
            taps[0] <= din;
            for (int i = 1; i < ddr_pad_pkg::DLY_DEPTH; i++) begin
                taps[i] <= taps[i-1];
            end
        end
    end

    assign dout = taps[dly];  // tap select, no extra register

    always_ff @(posedge mclk) begin
        if (rst) begin
            settle_cnt <= '0;
            dly_q      <= '0;
        end else begin
            dly_q <= dly;
            if (dly != dly_q) begin
                settle_cnt <= '0;
            end else if (settle_cnt != ddr_pad_pkg::DLY_DEPTH) begin
                settle_cnt <= settle_cnt + 1'b1;
            end
        end
    end

    // once the line has filled under a steady setting, dout is din delayed dly+1 cycles
    for (genvar k = 0; k < ddr_pad_pkg::DLY_DEPTH; k++) begin : g_chk
        a_delay : assert property (@(posedge mclk) disable iff (rst)
            (dly == k && settle_cnt > k) |-> (dout == $past(din, k + 1)));
    end

endmodule

`default_nettype wire

//--- source/lane_dir_fsm.sv
`timescale 1ns/1ns
`default_nettype none

module lane_dir_fsm (
    input  logic           mclk,
    input  logic           rst,
    input  logic           dq_tri_d,   // delayed dq tristate where 1 means released
    input  logic           dqs_tri_d,  // delayed dqs tristate where 1 means released
    pad_lane_if.fsm        lane
);

    ddr_pad_pkg::dir_state_t state;
    ddr_pad_pkg::dir_state_t next_state;
    logic                    oe_dqs_q;

    always_comb begin
        next_state = state;
        case (state)
            ddr_pad_pkg::RX: begin
                if (!dq_tri_d) begin
                    next_state = ddr_pad_pkg::DRIVE;
                end
            end
            ddr_pad_pkg::DRIVE: begin
                if (dq_tri_d) begin
                    next_state = ddr_pad_pkg::GAP;
                end
            end
            ddr_pad_pkg::GAP: begin
                next_state = ddr_pad_pkg::RX;  // single turnaround cycle
            end
            default: begin
                next_state = ddr_pad_pkg::RX;
            end
        endcase
    end

    always_ff @(posedge mclk) begin
        if (rst) begin
            state    <= ddr_pad_pkg::RX;
            oe_dqs_q <= 1'b0;
        end else begin
            state    <= next_state;
            oe_dqs_q <= ~dqs_tri_d;  // dqs enable ignores state
        end
    end

    assign lane.oe_dq   = (state == ddr_pad_pkg::DRIVE);
    assign lane.oe_dqs  = oe_dqs_q;
    assign lane.capture = (state == ddr_pad_pkg::RX);

    // load write data on the edge that turns the driver on
    assign lane.drive = (next_state == ddr_pad_pkg::DRIVE);

    // one released cycle without capture after the driver lets go
    a_gap_one : assert property (@(posedge mclk) disable iff (rst)
        $fell(lane.oe_dq) |-> !lane.capture ##1 lane.capture);

    // no read sampling while our own driver is on the pads or just after
    a_no_contention : assert property (@(posedge mclk) disable iff (rst)
        lane.oe_dq |-> !lane.capture ##1 !lane.capture);

endmodule

`default_nettype wire

//--- source/pad_lane_if.sv
`timescale 1ns/1ns
`default_nettype none

// direction control for one byte lane, FSM to data path
interface pad_lane_if;

    logic oe_dq;    // dq/dm output enable
    logic oe_dqs;   // dqs output enable
    logic drive;    // launch write data this edge
    logic capture;  // sample read data this edge

    modport fsm (
        output oe_dq,
        output oe_dqs,
        output drive,
        output capture
    );

    modport lane (
        input oe_dq,
        input oe_dqs,
        input drive,
        input capture
    );

endinterface

`default_nettype wire

//--- source/pad_turnaround_top.sv
`timescale 1ns/1ns
`default_nettype none

module pad_turnaround_top (
    input  logic              mclk,
    input  logic              rst,
    input  ddr_pad_pkg::dly_t dly_cfg,
    input  logic [1:0]        dq_tri,     // 1 = released
    input  logic [1:0]        dqs_tri,    // 1 = released
    input  logic [15:0]       wr_data,
    input  logic [1:0]        wr_dm,
    input  logic [15:0]       pad_dq_in,
    output logic [15:0]       pad_dq_out,
    output logic [1:0]        pad_dm_out,
    output logic [1:0]        pad_dq_oe,
    output logic [1:0]        pad_dqs_oe,
    output logic [15:0]       rd_data,
    output logic [1:0]        rd_valid
);

    logic [1:0] dq_tri_d;
    logic [1:0] dqs_tri_d;

    dly_16 #(
        .WIDTH (2 * ddr_pad_pkg::NUM_LANES)
    ) u_dly (
        .mclk (mclk),
        .rst  (rst),
        .dly  (dly_cfg),
        .din  ({dqs_tri, dq_tri}),
        .dout ({dqs_tri_d, dq_tri_d})
    );

    for (genvar i = 0; i < ddr_pad_pkg::NUM_LANES; i++) begin : g_lane
        pad_lane_if u_lane_if ();

        lane_dir_fsm u_fsm (
            .mclk      (mclk),
            .rst       (rst),
            .dq_tri_d  (dq_tri_d[i]),
            .dqs_tri_d (dqs_tri_d[i]),
            .lane      (u_lane_if.fsm)
        );

        byte_lane u_byte (
            .mclk     (mclk),
            .rst      (rst),
            .lane     (u_lane_if.lane),
            .wr_byte  (wr_data[i*ddr_pad_pkg::LANE_W +: ddr_pad_pkg::LANE_W]),
            .wr_mask  (wr_dm[i]),
            .pad_in   (pad_dq_in[i*ddr_pad_pkg::LANE_W +: ddr_pad_pkg::LANE_W]),
            .pad_out  (pad_dq_out[i*ddr_pad_pkg::LANE_W +: ddr_pad_pkg::LANE_W]),
            .dm_out   (pad_dm_out[i]),
            .rd_byte  (rd_data[i*ddr_pad_pkg::LANE_W +: ddr_pad_pkg::LANE_W]),
            .rd_valid (rd_valid[i])
        );

        assign pad_dq_oe[i]  = u_lane_if.oe_dq;
        assign pad_dqs_oe[i] = u_lane_if.oe_dqs;
    end

endmodule

`default_nettype wire
